// File: include/noc_config.svh
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Router inputs are Local, North, East, West and South.
`define NOC_PORTS 5

`define NOC_DATA_W 32
`define NOC_LEN_W 12

// Entries per input FIFO.
`define NOC_FIFO_DEPTH 4

`endif

// File: logic/flitPkg.sv
`include "noc_config.svh"

package flitPkg;

  // Head starts a packet, body follows it.
  typedef enum logic [1:0]
  {
    head = 2'b01,
    body = 2'b10
  } flitKindT;

  // Number of body flits after a head.
  typedef logic [`NOC_LEN_W-1:0] lengthT;

  // A head keeps its length in the low payload bits.
  typedef logic [`NOC_DATA_W-1:0] flitDataT;

  typedef struct packed
  {
    flitKindT kind;
    flitDataT data;
  } flitT;

endpackage

// File: logic/arbPkg.sv
package arbPkg;

  // Local=0, North=1, East=2, West=3, South=4.
  typedef logic [2:0] portIdT;

  // The owner is held next to the state.
  typedef enum logic
  {
    idle = 1'b0,
    busy = 1'b1
  } arbStateT;

endpackage

// File: logic/flitFifo.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module flitFifo
(
  input  logic          clk,
  input  logic          rst,
  input  logic          inValid,
  input  flitPkg::flitT inFlit,
  output logic          inReady,
  output logic          outValid,
  output flitPkg::flitT outFlit,
  input  logic          outReady
);

  localparam int ptrW = $clog2(`NOC_FIFO_DEPTH);
  localparam int cntW = $clog2(`NOC_FIFO_DEPTH + 1);

  flitPkg::flitT mem [`NOC_FIFO_DEPTH];

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic full;
  logic push;
  logic pop;

  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    if (ptr == ptrW'(`NOC_FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full = (count == cntW'(`NOC_FIFO_DEPTH));
  assign outValid = (count != '0);
  assign outFlit = mem[rdPtr];

  // A full FIFO still takes a flit when the head leaves in the same cycle.
  assign inReady = !full || outReady;

  assign push = inValid && inReady;
  assign pop = outValid && outReady;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: logic/packetTimer.sv
`timescale 1ns/1ns

module packetTimer
(
  input  logic          clk,
  input  logic          rst,
  input  logic          advance,
  input  flitPkg::flitT flit,
  output logic          packetLast
);

  flitPkg::lengthT length;
  flitPkg::lengthT count;
  flitPkg::lengthT nextCount;
  flitPkg::lengthT headLength;
  logic isHead;

  assign isHead = (flit.kind == flitPkg::head);
  assign headLength = flitPkg::lengthT'(flit.data);
  assign nextCount = count + 1'b1;

  // A zero-length head is a packet by itself; otherwise the body flit
  // that brings the count up to the length closes the packet.
  always_comb
  begin
    if (isHead)
      packetLast = (headLength == '0);
    else
      packetLast = (nextCount == length);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      length <= '0;
      count <= '0;
    end
    else if (advance)
    begin
      if (isHead)
      begin
        length <= headLength;
        count <= '0;
      end
      else
      begin
        count <= nextCount;
      end
    end
  end

endmodule

// File: logic/packetArbiter.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module packetArbiter
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`NOC_PORTS-1:0]  reqValid,
  input  flitPkg::flitT          reqFlit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0]  popReady,
  output logic                   outValid,
  output flitPkg::flitT          outFlit,
  input  logic                   outReady
);

  arbPkg::arbStateT state;
  arbPkg::portIdT owner;
  arbPkg::portIdT startPort;
  arbPkg::portIdT nextOwner;
  logic nextFound;

  logic [`NOC_PORTS-1:0] req;
  logic [`NOC_PORTS-1:0] reqMasked;
  logic [`NOC_PORTS-1:0] advance;
  logic [`NOC_PORTS-1:0] lastFlag;
  logic ownerAdvance;
  logic handover;

  // A port asks for the output when a head flit waits at its FIFO.
  always_comb
  begin
    for (int i = 0; i < `NOC_PORTS; i++)
      req[i] = reqValid[i] && (reqFlit[i].kind == flitPkg::head);
  end

  assign ownerAdvance = (state == arbPkg::busy) && reqValid[owner] && outReady;
  assign handover = ownerAdvance && lastFlag[owner];

  always_comb
  begin
    for (int i = 0; i < `NOC_PORTS; i++)
      advance[i] = ownerAdvance && (owner == arbPkg::portIdT'(i));
  end

  assign popReady = advance;

  // The owner's current head is leaving, so it cannot request again yet.
  always_comb
  begin
    for (int i = 0; i < `NOC_PORTS; i++)
      reqMasked[i] = req[i] && !(handover && (owner == arbPkg::portIdT'(i)));
  end

  // Search starts at Local from idle, else right after the old owner.
  always_comb
  begin
    if (state == arbPkg::idle)
      startPort = '0;
    else if (owner == arbPkg::portIdT'(`NOC_PORTS - 1))
      startPort = '0;
    else
      startPort = owner + 1'b1;
  end

  always_comb
  begin
    int idx;
    nextFound = 1'b0;
    nextOwner = owner;
    for (int k = 0; k < `NOC_PORTS; k++)
    begin
      idx = int'(startPort) + k;
      if (idx >= `NOC_PORTS)
        idx = idx - `NOC_PORTS;
      if (!nextFound && reqMasked[idx])
      begin
        nextFound = 1'b1;
        nextOwner = arbPkg::portIdT'(idx);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbPkg::idle;
      owner <= '0;
    end
    else if ((state == arbPkg::idle) || handover)
    begin
      if (nextFound)
      begin
        state <= arbPkg::busy;
        owner <= nextOwner;
      end
      else
      begin
        state <= arbPkg::idle;
      end
    end
  end

  // One timer per input follows the packet that input is sending.
  for (genvar g = 0; g < `NOC_PORTS; g++)
  begin : genTimer
    packetTimer timer
    (
      .clk        (clk),
      .rst        (rst),
      .advance    (advance[g]),
      .flit       (reqFlit[g]),
      .packetLast (lastFlag[g])
    );
  end

  assign outValid = (state == arbPkg::busy) && reqValid[owner];
  assign outFlit = reqFlit[owner];

endmodule

// File: logic/outputSwitch.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module outputSwitch
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`NOC_PORTS-1:0]  inValid,
  input  flitPkg::flitT          inFlit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0]  inReady,
  output logic                   outValid,
  output flitPkg::flitT          outFlit,
  input  logic                   outReady
);

  logic [`NOC_PORTS-1:0] fifoValid;
  flitPkg::flitT fifoFlit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] popReady;

  // Each input buffers its flits while another input owns the output.
  for (genvar g = 0; g < `NOC_PORTS; g++)
  begin : genFifo
    flitFifo fifo
    (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[g]),
      .inFlit   (inFlit[g]),
      .inReady  (inReady[g]),
      .outValid (fifoValid[g]),
      .outFlit  (fifoFlit[g]),
      .outReady (popReady[g])
    );
  end

  packetArbiter arbiter
  (
    .clk      (clk),
    .rst      (rst),
    .reqValid (fifoValid),
    .reqFlit  (fifoFlit),
    .popReady (popReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outReady (outReady)
  );

endmodule

// File: test/clockGen.sv
`timescale 1ns/1ns

module clockGen
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset covers the first five rising edges.
  initial
  begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

// File: test/switchChecker.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module switchChecker
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NOC_PORTS-1:0] inValid,
  input  flitPkg::flitT         inFlit [`NOC_PORTS],
  input  logic [`NOC_PORTS-1:0] inReady,
  input  logic                  outValid,
  input  flitPkg::flitT         outFlit,
  input  logic                  outReady,
  input  logic                  rrCheck,
  input  logic                  finished,
  output logic                  reported,
  output int                    passCount,
  output int                    failCount
);

  localparam int tReset = 0;
  localparam int tIntegrity = 1;
  localparam int tOrder = 2;
  localparam int tRoundRobin = 3;
  localparam int tBackpressure = 4;

  int checks [5] = '{default: 0};
  int errors [5] = '{default: 0};

  // Flits accepted at each input and not yet seen at the output.
  flitPkg::flitT expQ [`NOC_PORTS][$];

  bit resetArmed = 1'b0;
  bit resetDone = 1'b0;
  bit inPacket = 1'b0;
  arbPkg::portIdT pktPort;
  logic [12:0] pktSeq;
  int pktLen;
  int bodySeen;
  bit rrArmed = 1'b0;
  int rrExpected;
  bit holdPending = 1'b0;
  flitPkg::flitT heldFlit;
  bit prevRrCheck = 1'b0;

  task automatic compareValue(input int t, input string name,
                              input logic [33:0] expected, input logic [33:0] actual);
    checks[t]++;
    if (actual !== expected)
    begin
      errors[t]++;
      $display("mismatch %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic failCheck(input int t, input string message);
    checks[t]++;
    errors[t]++;
    $display("%s", message);
  endtask

  task automatic printTest(input int t, input string name);
    if (errors[t] == 0)
      $display("%s: ok, %0d checks", name, checks[t]);
    else
      $display("%s: %0d of %0d checks wrong", name, errors[t], checks[t]);
  endtask

  task automatic takeOutput();
    arbPkg::portIdT port;
    flitPkg::flitT expected;
    bit othersWaiting;
    port = outFlit.data[31:29];
    if (int'(port) >= `NOC_PORTS)
      failCheck(tOrder, $sformatf("output flit %h names no input port", outFlit));
    else if (expQ[port].size() == 0)
      failCheck(tOrder, $sformatf("output flit %h was never sent on port %0d", outFlit, port));
    else
      compareValue(tOrder, "order", expQ[port].pop_front(), outFlit);

    if (!inPacket)
    begin
      if (outFlit.kind != flitPkg::head)
      begin
        failCheck(tIntegrity, "a body flit left the switch outside any packet");
        return;
      end
      if (rrArmed)
        compareValue(tRoundRobin, "roundrobin", 34'(rrExpected), 34'(port));
      rrArmed = 1'b0;
      pktPort = port;
      pktSeq = outFlit.data[28:16];
      pktLen = int'(outFlit.data[11:0]);
      bodySeen = 0;
      inPacket = 1'b1;
    end
    else
    begin
      bodySeen++;
      expected.kind = flitPkg::body;
      expected.data = {pktPort, pktSeq, 16'(bodySeen)};
      compareValue(tIntegrity, "integrity", expected, outFlit);
    end

    if (bodySeen == pktLen)
    begin
      inPacket = 1'b0;
      // With every other input waiting, the grant moves one port on.
      othersWaiting = 1'b1;
      for (int p = 0; p < `NOC_PORTS; p++)
        if (p != int'(pktPort) && expQ[p].size() == 0)
          othersWaiting = 1'b0;
      rrArmed = rrCheck && othersWaiting;
      rrExpected = (int'(pktPort) + 1) % `NOC_PORTS;
    end
  endtask

  always @(posedge clk)
  begin
    if (resetArmed && !resetDone)
    begin
      compareValue(tReset, "reset", 34'h1f, {28'b0, outValid, inReady});
      if (!rst)
      begin
        resetDone = 1'b1;
        printTest(tReset, "reset");
      end
    end
    if (rst)
      resetArmed = 1'b1;

    if (!rst)
    begin
      if (holdPending)
      begin
        if (outValid !== 1'b1)
          failCheck(tBackpressure, "output valid dropped while the output was stalled");
        else
          compareValue(tBackpressure, "backpressure", heldFlit, outFlit);
      end
      holdPending = outValid && !outReady;
      heldFlit = outFlit;
      if (outValid && outReady)
        takeOutput();
      // Inputs are taken after the output, as they reach a FIFO head later.
      for (int p = 0; p < `NOC_PORTS; p++)
        if (inValid[p] && inReady[p])
          expQ[p].push_back(inFlit[p]);
    end

    if (prevRrCheck && !rrCheck)
    begin
      if (checks[tRoundRobin] == 0)
        failCheck(tRoundRobin, "no packet handover was seen while all inputs were waiting");
      printTest(tRoundRobin, "roundrobin");
    end
    prevRrCheck = rrCheck;

    if (finished && reported !== 1'b1)
    begin
      if (inPacket)
        failCheck(tIntegrity, "the last packet at the output was never completed");
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        if (expQ[p].size() != 0)
          failCheck(tOrder, $sformatf("port %0d still holds %0d flits that never came out",
                                      p, expQ[p].size()));
        else
          checks[tOrder]++;
      end
      printTest(tIntegrity, "integrity");
      printTest(tOrder, "order");
      printTest(tBackpressure, "backpressure");
      passCount = 0;
      failCount = 0;
      for (int t = 0; t < 5; t++)
      begin
        passCount += checks[t] - errors[t];
        failCount += errors[t];
      end
      reported = 1'b1;
    end
  end

endmodule

// File: test/switchTb.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module switchTb;

  typedef enum int {modeRandom, modeSatHold, modeSatRun, modeDrain} modeT;

  localparam int randPackets = 12;
  localparam int satPackets = 5;

  logic clk;
  logic rst;
  logic [`NOC_PORTS-1:0] inValid = '0;
  flitPkg::flitT inFlit [`NOC_PORTS] = '{default: '0};
  logic [`NOC_PORTS-1:0] inReady;
  logic outValid;
  flitPkg::flitT outFlit;
  logic outReady = 1'b0;

  logic rrCheck = 1'b0;
  logic finished = 1'b0;
  logic reported;
  int passCount;
  int failCount;

  modeT mode = modeRandom;
  logic [31:0] lfsr = 32'hb43a;
  flitPkg::flitT pending [`NOC_PORTS][$];
  flitPkg::flitT satQ [`NOC_PORTS][$];
  int seqNum [`NOC_PORTS] = '{default: 0};
  int totalFlits = 0;
  int sentCount = 0;
  int recvCount = 0;
  bit built = 1'b0;
  bit satLoaded = 1'b0;

  clockGen clocks
  (
    .clk (clk),
    .rst (rst)
  );

  outputSwitch uut
  (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outReady (outReady)
  );

  switchChecker monitor
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlit    (inFlit),
    .inReady   (inReady),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outReady  (outReady),
    .rrCheck   (rrCheck),
    .finished  (finished),
    .reported  (reported),
    .passCount (passCount),
    .failCount (failCount)
  );

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  function automatic int unsigned randBits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrStep(lfsr);
      v = (v << 1) | {31'b0, lfsr[0]};
    end
    return v;
  endfunction

  function automatic void storeFlit(input int p, input bit toSat, input flitPkg::flitT f);
    if (toSat)
      satQ[p].push_back(f);
    else
      pending[p].push_back(f);
  endfunction

  // A head holds the port in 31:29, the sequence in 28:16 and the length in 11:0.
  // Body flits carry the port, the sequence and their index from 1.
  function automatic void appendPacket(input int p, input bit toSat);
    flitPkg::flitT f;
    int len;
    len = int'(randBits(3));
    f.kind = flitPkg::head;
    f.data = {3'(p), 13'(seqNum[p]), 4'b0, 12'(len)};
    storeFlit(p, toSat, f);
    for (int i = 1; i <= len; i++)
    begin
      f.kind = flitPkg::body;
      f.data = {3'(p), 13'(seqNum[p]), 16'(i)};
      storeFlit(p, toSat, f);
    end
    seqNum[p]++;
    totalFlits += len + 1;
  endfunction

  function automatic bit pendingEmpty();
    for (int p = 0; p < `NOC_PORTS; p++)
      if (pending[p].size() != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  always @(posedge clk)
  begin
    logic offer;
    if (rst)
    begin
      inValid <= '0;
      outReady <= 1'b0;
      if (!built)
      begin
        for (int p = 0; p < `NOC_PORTS; p++)
        begin
          for (int k = 0; k < randPackets; k++)
            appendPacket(p, 1'b0);
          for (int k = 0; k < satPackets; k++)
            appendPacket(p, 1'b1);
        end
        built = 1'b1;
      end
    end
    else
    begin
      if (outValid && outReady)
        recvCount++;
      if (mode == modeSatHold && !satLoaded)
      begin
        for (int p = 0; p < `NOC_PORTS; p++)
          pending[p] = satQ[p];
        satLoaded = 1'b1;
      end
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        if (inValid[p] && inReady[p])
        begin
          void'(pending[p].pop_front());
          sentCount++;
        end
        // A flit that was not taken stays on the port unchanged.
        if (!(inValid[p] && !inReady[p]))
        begin
          offer = 1'b0;
          if (pending[p].size() != 0)
            offer = (mode != modeRandom) || (randBits(2) != 0);
          inValid[p] <= offer;
          if (offer)
            inFlit[p] <= pending[p][0];
        end
      end
      case (mode)
        modeRandom: outReady <= (randBits(4) < 11);
        modeSatHold: outReady <= 1'b0;
        default: outReady <= 1'b1;
      endcase
    end
  end

  initial
  begin
    wait (rst === 1'b0);
    do
      @(negedge clk);
    while (!(pendingEmpty() && recvCount == sentCount));

    // Stall the output until every FIFO is full behind a head flit.
    mode = modeSatHold;
    rrCheck = 1'b1;
    do
      @(negedge clk);
    while (inReady != '0);

    mode = modeSatRun;
    do
      @(negedge clk);
    while (!pendingEmpty());

    mode = modeDrain;
    rrCheck = 1'b0;
    do
      @(negedge clk);
    while (recvCount != sentCount);

    finished = 1'b1;
    do
      @(negedge clk);
    while (reported !== 1'b1);

    $display("checks passed: %0d, checks failed: %0d", passCount, failCount);
    if (failCount == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    wait (built);
    repeat (totalFlits * 20 + 2000) @(posedge clk);
    $display("Watchdog expired: the switch stopped delivering flits in time");
    $display("Test failed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
logic/flitPkg.sv
logic/arbPkg.sv
logic/flitFifo.sv
logic/packetTimer.sv
logic/packetArbiter.sv
logic/outputSwitch.sv
test/clockGen.sv
test/switchChecker.sv
test/switchTb.sv

// File: Makefile
SOURCES := $(wildcard logic/*.sv test/*.sv include/*.svh)

.PHONY: run clean

run: obj_dir/VswitchTb
	./obj_dir/VswitchTb | tee sim.log
	grep -q "Test completed successfully" sim.log

obj_dir/VswitchTb: tb.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ns --top-module switchTb -f tb.f

clean:
	rm -rf obj_dir sim.log
